// ==== rtl/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ------------------------------------------------------------
// core sizing
// ------------------------------------------------------------

// data word and register width
`define RV_XLEN 32

// byte address width on the APB side
`define RV_ADDR_WIDTH 17

// architectural registers, x0 included
`define RV_REG_COUNT 32

// address of the first fetch
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rtl/rv_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    // ------------------------------------------------------------
    // decode classes
    // ------------------------------------------------------------

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_REG,
        ALU_IMM,
        ALU_ADDR,
        ALU_BRANCH,
        ALU_PASS_IMM,
        ALU_PC_IMM
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // everything the later stages need from one instruction
    typedef struct packed {
        alu_op_e              alu_op;
        mem_op_e              mem_op;
        branch_op_e           branch_op;
        wb_sel_e              wb_sel;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [3:0]           func;
        logic [`RV_XLEN-1:0]  imm;
    } ctrl_t;

    // ------------------------------------------------------------
    // bus request and response
    // ------------------------------------------------------------

    typedef struct packed {
        logic                      write;
        logic [`RV_ADDR_WIDTH-1:0] addr;
        logic [`RV_XLEN-1:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0] instr,
    output rv_pkg::ctrl_t       ctrl
);
    import rv_pkg::*;

    // base opcodes of the kept instructions
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                is_shift;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // only the immediate shifts carry a real bit 30
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // ------------------------------------------------------------
    // immediates, all sign extended
    // ------------------------------------------------------------
    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // ------------------------------------------------------------
    // control fields per opcode
    // ------------------------------------------------------------
    always_comb begin
        ctrl      = '0;
        ctrl.rd   = instr[11:7];
        ctrl.rs1  = instr[19:15];
        ctrl.rs2  = instr[24:20];
        ctrl.func = {instr[30], funct3};
        case (opcode)
            OP_REG: begin
                ctrl.alu_op = ALU_REG;
                ctrl.wb_sel = WB_ALU;
            end
            OP_IMM: begin
                ctrl.alu_op = ALU_IMM;
                ctrl.wb_sel = WB_ALU;
                ctrl.imm    = imm_i;
                ctrl.func   = {is_shift & instr[30], funct3};
            end
            OP_LOAD: begin
                ctrl.alu_op = ALU_ADDR;
                ctrl.mem_op = MEM_READ;
                ctrl.wb_sel = WB_MEM;
                ctrl.imm    = imm_i;
            end
            OP_STORE: begin
                ctrl.alu_op = ALU_ADDR;
                ctrl.mem_op = MEM_WRITE;
                ctrl.imm    = imm_s;
            end
            OP_BRANCH: begin
                ctrl.alu_op    = ALU_BRANCH;
                ctrl.branch_op = BR_COND;
                ctrl.imm       = imm_b;
            end
            OP_JAL: begin
                ctrl.branch_op = BR_JAL;
                ctrl.wb_sel    = WB_PC4;
                ctrl.imm       = imm_j;
            end
            OP_JALR: begin
                ctrl.alu_op    = ALU_ADDR;
                ctrl.branch_op = BR_JALR;
                ctrl.wb_sel    = WB_PC4;
                ctrl.imm       = imm_i;
            end
            OP_LUI: begin
                ctrl.alu_op = ALU_PASS_IMM;
                ctrl.wb_sel = WB_ALU;
                ctrl.imm    = imm_u;
            end
            OP_AUIPC: begin
                ctrl.alu_op = ALU_PC_IMM;
                ctrl.wb_sel = WB_ALU;
                ctrl.imm    = imm_u;
            end
            // unknown opcode runs as a no-op
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_alu (
    input  rv_pkg::alu_op_e     op,
    input  logic [3:0]          func,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] result,
    output logic                equal
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] opb;
    logic [4:0]          shamt;
    logic                less;

    // second operand is rs2 only for register ops
    assign opb   = (op == ALU_REG) ? b : imm;
    assign shamt = opb[4:0];
    assign less  = $signed(a) < $signed(opb);

    // branch compare, used by BEQ and BNE
    assign equal = (op == ALU_BRANCH) && (a == b);

    always_comb begin
        result = '0;
        case (op)
            ALU_REG, ALU_IMM: begin
                // func is {bit 30, funct3}
                case (func)
                    4'b0000: result = a + opb;
                    4'b1000: result = a - opb;
                    4'b0001: result = a << shamt;
                    4'b0010: result = {{(`RV_XLEN-1){1'b0}}, less};
                    4'b0100: result = a ^ opb;
                    4'b0101: result = a >> shamt;
                    4'b1101: result = $signed(a) >>> shamt;
                    4'b0110: result = a | opb;
                    4'b0111: result = a & opb;
                    default: result = '0;
                endcase
            end
            ALU_ADDR:     result = a + imm;
            ALU_PASS_IMM: result = imm;
            ALU_PC_IMM:   result = pc + imm;
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                wen,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // x0 is cleared here and never written after
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // asynchronous read ports
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst,
    output logic             req_valid,
    output rv_pkg::mem_req_t req,
    input  logic             done,
    input  rv_pkg::mem_rsp_t rsp
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK
    } state_e;

    state_e              state;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] ir;

    // decode and execute registers
    ctrl_t               de_ctrl;
    logic [`RV_XLEN-1:0] de_rs1_val;
    logic [`RV_XLEN-1:0] de_rs2_val;
    logic [`RV_XLEN-1:0] ex_result;
    logic                ex_equal;
    logic [`RV_XLEN-1:0] wb_data;

    ctrl_t               dec_ctrl;
    logic [`RV_XLEN-1:0] rf_rdata1;
    logic [`RV_XLEN-1:0] rf_rdata2;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_equal;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] wb_next;
    logic                take;
    logic                mem_exit;

    rv_decoder dec0 (
        .instr (ir),
        .ctrl  (dec_ctrl)
    );

    rv_reg_file rf0 (
        .clk    (clk),
        .rst    (rst),
        .rs1    (dec_ctrl.rs1),
        .rs2    (dec_ctrl.rs2),
        .rd     (de_ctrl.rd),
        .wen    ((state == ST_WRITEBACK) && (de_ctrl.wb_sel != WB_NONE)),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    rv_alu alu0 (
        .op     (de_ctrl.alu_op),
        .func   (de_ctrl.func),
        .a      (de_rs1_val),
        .b      (de_rs2_val),
        .imm    (de_ctrl.imm),
        .pc     (pc),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // ------------------------------------------------------------
    // branch resolution and writeback select
    // ------------------------------------------------------------
    assign pc_plus4 = pc + `RV_XLEN'(4);

    always_comb begin
        case (de_ctrl.branch_op)
            // funct3 bit 0 set means BNE
            BR_COND: take = de_ctrl.func[0] ? !ex_equal : ex_equal;
            BR_JAL:  take = 1'b1;
            BR_JALR: take = 1'b1;
            default: take = 1'b0;
        endcase
        if (!take) begin
            next_pc = pc_plus4;
        end else if (de_ctrl.branch_op == BR_JALR) begin
            next_pc = {ex_result[`RV_XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc + de_ctrl.imm;
        end
        case (de_ctrl.wb_sel)
            WB_MEM:  wb_next = rsp.rdata;
            WB_PC4:  wb_next = pc_plus4;
            default: wb_next = ex_result;
        endcase
    end

    // memory stage ends at once without a bus access
    assign mem_exit = (state == ST_MEMORY)
                   && ((de_ctrl.mem_op == MEM_NONE) || (req_valid && done));

    // fetch reads at the PC, the memory stage uses the ALU address
    always_comb begin
        req.wdata = de_rs2_val;
        if (state == ST_MEMORY) begin
            req.write = (de_ctrl.mem_op == MEM_WRITE);
            req.addr  = ex_result[`RV_ADDR_WIDTH-1:0];
        end else begin
            req.write = 1'b0;
            req.addr  = pc[`RV_ADDR_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_FETCH;
            pc        <= `RV_RESET_PC;
            req_valid <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!req_valid) begin
                        req_valid <= 1'b1;
                    end else if (done) begin
                        req_valid <= 1'b0;
                        state     <= ST_DECODE;
                    end
                end
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: state <= ST_MEMORY;
                ST_MEMORY: begin
                    if (mem_exit) begin
                        req_valid <= 1'b0;
                        pc        <= next_pc;
                        state     <= ST_WRITEBACK;
                    end else if (!req_valid) begin
                        req_valid <= 1'b1;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && req_valid && done) begin
            ir <= rsp.rdata;
        end
        if (state == ST_DECODE) begin
            de_ctrl    <= dec_ctrl;
            de_rs1_val <= rf_rdata1;
            de_rs2_val <= rf_rdata2;
        end
        if (state == ST_EXECUTE) begin
            ex_result <= alu_result;
            ex_equal  <= alu_equal;
        end
        if (mem_exit) begin
            wb_data <= wb_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/apb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module apb_master (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  rv_pkg::mem_req_t          req,
    output logic                      done,
    output rv_pkg::mem_rsp_t          rsp,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [`RV_ADDR_WIDTH-1:0] paddr,
    output logic [`RV_XLEN-1:0]       pwdata,
    input  logic [`RV_XLEN-1:0]       prdata,
    input  logic                      pready
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e   state;
    mem_req_t req_q;
    logic     start;

    // req_valid is still high in the done cycle, so skip it there
    assign start = (state == ST_IDLE) && req_valid && !done;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: state <= ST_ACCESS;
                ST_ACCESS: begin
                    // wait states hold the access phase
                    if (pready) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= req;
        end
        if (state == ST_ACCESS && pready) begin
            rsp.rdata <= prdata;
        end
    end

    // ------------------------------------------------------------
    // bus pins
    // ------------------------------------------------------------
    assign psel    = (state != ST_IDLE);
    assign penable = (state == ST_ACCESS);
    assign pwrite  = req_q.write;
    assign paddr   = req_q.addr;
    assign pwdata  = req_q.wdata;

endmodule

`default_nettype wire

// ==== rtl/rv_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_cpu_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [`RV_ADDR_WIDTH-1:0] paddr,
    output logic [`RV_XLEN-1:0]       pwdata,
    input  logic [`RV_XLEN-1:0]       prdata,
    input  logic                      pready
);
    import rv_pkg::*;

    // one request at a time between core and bus
    logic     req_valid;
    mem_req_t req;
    logic     done;
    mem_rsp_t rsp;

    rv_core core0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp)
    );

    apb_master apb0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

endmodule

`default_nettype wire

// ==== tests/apb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module apb_mem_model (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`RV_ADDR_WIDTH-1:0] paddr,
    input  logic [`RV_XLEN-1:0]       pwdata,
    output logic [`RV_XLEN-1:0]       prdata,
    output logic                      pready,
    output logic                      wr_valid,
    output rv_pkg::mem_req_t          wr_rec,
    output int                        proto_errors
);

    localparam int WORDS = 2 ** (`RV_ADDR_WIDTH - 2);

    logic [`RV_XLEN-1:0]       mem [WORDS];
    integer                    seed = 59225;
    logic [`RV_XLEN-1:0]       rnd;
    logic [1:0]                waits;
    logic [`RV_XLEN-1:0]       rdata_q = '0;
    logic                      ready_q = 1'b0;
    logic                      first_seen;

    // bus state seen at the previous falling edge
    logic                      prev_psel;
    logic                      prev_penable;
    logic                      prev_ready;
    logic [`RV_ADDR_WIDTH-1:0] prev_addr;
    logic                      prev_write;
    logic [`RV_XLEN-1:0]       prev_wdata;

    assign prdata = rdata_q;
    assign pready = ready_q;

    // filler word built from the whole word index
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {2'b10, i[14:0], ~i[14:0]};
        end
    end

    always @(negedge clk) begin
        wr_valid = 1'b0;
        if (!rst) begin
            ready_q      = 1'b0;
            waits        = 2'd0;
            first_seen   = 1'b0;
            prev_psel    = 1'b0;
            prev_penable = 1'b0;
            prev_ready   = 1'b0;
            proto_errors = 0;
        end else begin
            // ------------------------------------------------------------
            // protocol checks
            // ------------------------------------------------------------
            if (penable) begin
                assert (psel) else begin
                    $display("penable is high while psel is low");
                    proto_errors = proto_errors + 1;
                end
            end
            if (penable && !prev_penable) begin
                assert (prev_psel) else begin
                    $display("penable rose without a setup cycle before it");
                    proto_errors = proto_errors + 1;
                end
            end
            if (prev_psel && !prev_penable) begin
                assert (psel && penable) else begin
                    $display("a setup cycle was not followed by an access cycle");
                    proto_errors = proto_errors + 1;
                end
            end
            if (psel && prev_psel && !(prev_penable && prev_ready)) begin
                assert ((paddr === prev_addr) && (pwrite === prev_write)
                        && (pwdata === prev_wdata)) else begin
                    $display("address, direction or write data changed during a transfer");
                    proto_errors = proto_errors + 1;
                end
            end
            if (psel && !prev_psel && !first_seen) begin
                first_seen = 1'b1;
                assert ((paddr === `RV_ADDR_WIDTH'(`RV_RESET_PC)) && (pwrite === 1'b0)) else begin
                    $display("** Error: first fetch paddr = 0x%h, expected 0x%h",
                             paddr, `RV_ADDR_WIDTH'(`RV_RESET_PC));
                    proto_errors = proto_errors + 1;
                end
            end

            // ------------------------------------------------------------
            // wait states and data
            // ------------------------------------------------------------
            if (psel && !penable) begin
                rnd     = $random(seed);
                waits   = rnd[1:0];
                ready_q = 1'b0;
            end else if (psel && penable && !ready_q) begin
                if (waits == 2'd0) begin
                    // transfer completes at the next rising edge
                    ready_q = 1'b1;
                    if (pwrite) begin
                        mem[paddr[`RV_ADDR_WIDTH-1:2]] = pwdata;
                        wr_rec   = {1'b1, paddr, pwdata};
                        wr_valid = 1'b1;
                    end else begin
                        rdata_q = mem[paddr[`RV_ADDR_WIDTH-1:2]];
                    end
                end else begin
                    waits = waits - 2'd1;
                end
            end else begin
                ready_q = 1'b0;
            end

            prev_psel    = psel;
            prev_penable = penable;
            prev_ready   = ready_q;
            prev_addr    = paddr;
            prev_write   = pwrite;
            prev_wdata   = pwdata;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_rv_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_cpu;
    import rv_pkg::*;

    localparam int PROG_LEN     = 60;
    localparam int NUM_ROWS     = 25;
    localparam int RESET_CYCLES = 16;
    localparam int TAIL_CYCLES  = 40;
    // no instruction needs 20 cycles, even with 3 wait states on both transfers
    localparam int CYCLE_LIMIT  = PROG_LEN * 20 + RESET_CYCLES + TAIL_CYCLES;

    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    logic                      clk;
    logic                      rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`RV_ADDR_WIDTH-1:0] paddr;
    logic [`RV_XLEN-1:0]       pwdata;
    logic [`RV_XLEN-1:0]       prdata;
    logic                      pready;
    logic                      wr_valid;
    mem_req_t                  wr_rec;
    int                        proto_errors;

    logic [`RV_XLEN-1:0] prog [PROG_LEN];
    mem_req_t            expected [NUM_ROWS];
    int                  row;
    int                  pass_count;
    int                  fail_count;
    int                  extra_count;
    int                  cycles;
    logic                row_ok;

    rv_cpu_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    apb_mem_model mem0 (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .wr_valid     (wr_valid),
        .wr_rec       (wr_rec),
        .proto_errors (proto_errors)
    );

    // ------------------------------------------------------------
    // RV32I instruction formats
    // ------------------------------------------------------------
    function automatic logic [31:0] rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    // sw only
    function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jtype(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic mem_req_t make_store(input int addr, input logic [31:0] data);
        return {1'b1, addr[`RV_ADDR_WIDTH-1:0], data};
    endfunction

    // x1 = 100, x2 = -7, x10 = data base 0x400
    task automatic build_program();
        prog[0]  = itype(1024, 0, 3'd0, 10, OP_IMM);
        prog[1]  = itype(100, 0, 3'd0, 1, OP_IMM);
        prog[2]  = itype(-7, 0, 3'd0, 2, OP_IMM);
        prog[3]  = rtype(7'h00, 2, 1, 3'd0, 3);       // add x3, x1, x2
        prog[4]  = stype(0, 3, 10);
        prog[5]  = rtype(7'h20, 1, 2, 3'd0, 4);       // sub x4, x2, x1
        prog[6]  = stype(4, 4, 10);
        prog[7]  = rtype(7'h00, 2, 1, 3'd7, 5);       // and
        prog[8]  = stype(8, 5, 10);
        prog[9]  = rtype(7'h00, 2, 1, 3'd6, 6);       // or
        prog[10] = stype(12, 6, 10);
        prog[11] = rtype(7'h00, 2, 1, 3'd4, 7);       // xor
        prog[12] = stype(16, 7, 10);
        prog[13] = rtype(7'h00, 1, 2, 3'd2, 8);       // slt x8, x2, x1
        prog[14] = stype(20, 8, 10);
        prog[15] = rtype(7'h00, 2, 1, 3'd1, 9);       // sll x9, x1, x2
        prog[16] = stype(24, 9, 10);
        prog[17] = rtype(7'h00, 1, 2, 3'd5, 11);      // srl x11, x2, x1
        prog[18] = stype(28, 11, 10);
        prog[19] = rtype(7'h20, 1, 2, 3'd5, 12);      // sra x12, x2, x1
        prog[20] = stype(32, 12, 10);
        prog[21] = itype(240, 2, 3'd7, 13, OP_IMM);   // andi
        prog[22] = stype(36, 13, 10);
        prog[23] = itype(-256, 1, 3'd6, 14, OP_IMM);  // ori
        prog[24] = stype(40, 14, 10);
        prog[25] = itype(-1, 2, 3'd4, 15, OP_IMM);    // xori
        prog[26] = stype(44, 15, 10);
        prog[27] = itype(-6, 2, 3'd2, 16, OP_IMM);    // slti
        prog[28] = stype(48, 16, 10);
        prog[29] = itype(3, 1, 3'd1, 17, OP_IMM);     // slli
        prog[30] = stype(52, 17, 10);
        prog[31] = itype(28, 2, 3'd5, 18, OP_IMM);    // srli
        prog[32] = stype(56, 18, 10);
        prog[33] = itype('h401, 2, 3'd5, 19, OP_IMM); // srai by 1
        prog[34] = stype(60, 19, 10);
        prog[35] = utype('h12345, 20, OP_LUI);
        prog[36] = stype(64, 20, 10);
        prog[37] = utype(1, 21, OP_AUIPC);            // at 0x094
        prog[38] = stype(68, 21, 10);
        prog[39] = stype(128, 4, 10);
        prog[40] = itype(128, 10, 3'd2, 22, OP_LOAD); // lw x22
        prog[41] = stype(72, 22, 10);
        prog[42] = itype(5, 0, 3'd0, 0, OP_IMM);      // write to x0 is dropped
        prog[43] = stype(76, 0, 10);
        // skipped paths store x1 to 0x7f0
        prog[44] = btype(8, 1, 1, 3'd0);              // beq taken
        prog[45] = stype(1008, 1, 10);
        prog[46] = btype(8, 2, 1, 3'd0);              // beq not taken
        prog[47] = stype(80, 3, 10);
        prog[48] = btype(8, 2, 1, 3'd1);              // bne taken
        prog[49] = stype(1008, 1, 10);
        prog[50] = btype(8, 1, 1, 3'd1);              // bne not taken
        prog[51] = stype(84, 8, 10);
        prog[52] = jtype(8, 23);                      // jal at 0x0d0
        prog[53] = stype(1008, 1, 10);
        prog[54] = stype(88, 23, 10);
        prog[55] = itype('hE9, 0, 3'd0, 24, OP_IMM);  // odd target, bit 0 cleared
        prog[56] = itype(0, 24, 3'd0, 25, OP_JALR);   // jalr at 0x0e0
        prog[57] = stype(1008, 1, 10);
        prog[58] = stype(92, 25, 10);
        prog[59] = jtype(0, 0);                       // park here
    endtask

    task automatic build_expected();
        expected[0]  = make_store('h400, 32'h0000_005D);
        expected[1]  = make_store('h404, 32'hFFFF_FF95);
        expected[2]  = make_store('h408, 32'h0000_0060);
        expected[3]  = make_store('h40C, 32'hFFFF_FFFD);
        expected[4]  = make_store('h410, 32'hFFFF_FF9D);
        expected[5]  = make_store('h414, 32'h0000_0001);
        expected[6]  = make_store('h418, 32'hC800_0000);
        expected[7]  = make_store('h41C, 32'h0FFF_FFFF);
        expected[8]  = make_store('h420, 32'hFFFF_FFFF);
        expected[9]  = make_store('h424, 32'h0000_00F0);
        expected[10] = make_store('h428, 32'hFFFF_FF64);
        expected[11] = make_store('h42C, 32'h0000_0006);
        expected[12] = make_store('h430, 32'h0000_0001);
        expected[13] = make_store('h434, 32'h0000_0320);
        expected[14] = make_store('h438, 32'h0000_000F);
        expected[15] = make_store('h43C, 32'hFFFF_FFFC);
        expected[16] = make_store('h440, 32'h1234_5000);
        expected[17] = make_store('h444, 32'h0000_1094);
        expected[18] = make_store('h480, 32'hFFFF_FF95);
        expected[19] = make_store('h448, 32'hFFFF_FF95);
        expected[20] = make_store('h44C, 32'h0000_0000);
        expected[21] = make_store('h450, 32'h0000_005D);
        expected[22] = make_store('h454, 32'h0000_0001);
        expected[23] = make_store('h458, 32'h0000_00D4);
        expected[24] = make_store('h45C, 32'h0000_00E4);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reset, program load and store checks
    // ------------------------------------------------------------
    initial begin
        rst         = 1'b0;
        row         = 0;
        pass_count  = 0;
        fail_count  = 0;
        extra_count = 0;
        build_program();
        build_expected();
        @(negedge clk);
        for (int i = 0; i < PROG_LEN; i++) begin
            mem0.mem[i] = prog[i];
        end
        repeat (RESET_CYCLES - 1) @(negedge clk);
        rst = 1'b1;

        for (row = 0; row < NUM_ROWS; row++) begin
            row_ok = 1'b1;
            @(posedge clk);
            while (!wr_valid) @(posedge clk);
            assert (wr_rec.addr == expected[row].addr) else begin
                $display("** Error: test %0d paddr = 0x%h, expected 0x%h",
                         row, wr_rec.addr, expected[row].addr);
                row_ok = 1'b0;
            end
            assert (wr_rec.wdata == expected[row].wdata) else begin
                $display("** Error: test %0d pwdata = 0x%h, expected 0x%h",
                         row, wr_rec.wdata, expected[row].wdata);
                row_ok = 1'b0;
            end
            if (row_ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d store to 0x%h: %s", row, expected[row].addr,
                     row_ok ? "pass" : "fail");
        end

        // the program is parked now, nothing more may be written
        repeat (TAIL_CYCLES) begin
            @(posedge clk);
            assert (!wr_valid) else begin
                $display("an unexpected store to 0x%h came after the last expected one",
                         wr_rec.addr);
                extra_count++;
            end
        end

        $display("%0d tests passed, %0d failed, %0d protocol errors, %0d extra stores",
                 pass_count, fail_count, proto_errors, extra_count);
        if (fail_count == 0 && proto_errors == 0 && extra_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // cycle counter for the timeout
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (row < NUM_ROWS) begin
            $display("timeout after %0d cycles: store %0d to 0x%h never came",
                     cycles, row, expected[row].addr);
        end else begin
            $display("timeout after %0d cycles: the run did not finish", cycles);
        end
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_reg_file.sv
rtl/rv_core.sv
rtl/apb_master.sv
rtl/rv_cpu_top.sv
tests/apb_mem_model.sv
tests/tb_rv_cpu.sv
